// File: run_sim.sh
#!/bin/sh
# Builds the video testbench with Verilator, runs it and
# checks the log for the pass message.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module video_tb -f sim.f -o video_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# Keep running after an assertion error so the testbench reports it.
./obj_dir/video_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$log"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: sim.f
source/video_pkg.sv
source/video_timing.sv
source/wb_video_regs.sv
source/channel_pattern.sv
source/pixel_merge.sv
source/video_top.sv
sim/video_props.sv
sim/video_tb.sv

// File: sim/video_props.sv
// ==================================================
// Concurrent checks on the video source, bound into
// the top level. Covers ack, blanking and hsync width.
// ==================================================
`timescale 1ns/1ps

module video_props import video_pkg::*; #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter bit h_pol    = 1'b0
) (
  input logic   clk,
  input logic   reset_n,
  input logic   wb_cyc,
  input logic   wb_stb,
  input logic   wb_ack,
  input pixel_t pixel
);

  // First position after the hsync window.
  localparam logic [coord_w-1:0] hs_end = coord_w'(h_active + h_front + h_sync);

  int   fail_cnt = 0;
  int   hs_run;
  logic hs_act;

  assign hs_act = (pixel.hsync == h_pol);

  // Consecutive valid pixels with hsync active.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hs_run <= 0;
    end else if (pixel.valid) begin
      hs_run <= hs_act ? hs_run + 1 : 0;
    end
  end

  // ==================================================
  // Properties.
  // ==================================================
  a_ack_single: assert property (@(posedge clk) disable iff (!reset_n)
    (wb_ack && wb_cyc && wb_stb) |=> !wb_ack)
    else begin
      fail_cnt++;
      $error("wishbone ack stayed high for two cycles");
    end

  a_blank_black: assert property (@(posedge clk) disable iff (!reset_n)
    (pixel.valid && pixel.blank) |-> (pixel.rgb == '0))
    else begin
      fail_cnt++;
      $error("blanked pixel carries colour");
    end

  a_hsync_width: assert property (@(posedge clk) disable iff (!reset_n)
    (pixel.valid && pixel.hcnt == hs_end) |-> (hs_run == h_sync))
    else begin
      fail_cnt++;
      $error("hsync run length differs from the sync width");
    end

endmodule

bind video_top video_props #(
  .h_active (h_active),
  .h_front  (h_front),
  .h_sync   (h_sync),
  .h_pol    (h_pol)
) i_video_props (
  .clk     (clk),
  .reset_n (reset_n),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_ack  (wb_ack),
  .pixel   (pixel)
);

// File: sim/video_tb.sv
// ==================================================
// Testbench for the video pattern source. Programs the
// Wishbone registers from a stimulus table and checks
// tagged pixels against the pattern and sync rules.
// ==================================================
`timescale 1ns/1ps

module video_tb import video_pkg::*; ();

  // ==================================================
  // Small frame geometry, 24 by 13 in total.
  // ==================================================
  localparam int h_active     = 16;
  localparam int h_front      = 2;
  localparam int h_sync       = 3;
  localparam int h_back       = 3;
  localparam int v_active     = 8;
  localparam int v_front      = 1;
  localparam int v_sync       = 2;
  localparam int v_back       = 2;
  localparam int h_total      = h_active + h_front + h_sync + h_back;
  localparam int v_total      = v_active + v_front + v_sync + v_back;
  localparam int frame_pixels = h_total * v_total;
  localparam int hs_start     = h_active + h_front;
  localparam int vs_start     = v_active + v_front;

  localparam int num_tests   = 17;
  localparam int max_div     = 7;
  // Table rows plus register and rate tests, three frames each.
  localparam int cycle_limit = (num_tests + 2) * 3 * frame_pixels * (max_div + 1);

  // One stimulus row with its expected pixel.
  typedef struct packed {
    logic [div_w-1:0]        divider;
    pattern_e                mode;
    logic [level_w-1:0]      red;
    logic [level_w-1:0]      green;
    logic [level_w-1:0]      blue;
    logic [coord_w-1:0]      h;
    logic [coord_w-1:0]      v;
    logic [3*level_w-1:0]    rgb_exp;
    logic                    hsync_exp;
    logic                    vsync_exp;
    logic                    blank_exp;
  } test_row_t;

  logic                  clk;
  logic                  reset_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [reg_addr_w-1:0] wb_adr;
  logic [31:0]           wb_dat_w;
  logic [31:0]           wb_dat_r;
  logic                  wb_ack;
  pixel_t                pixel;

  test_row_t rows [num_tests];
  string     names [num_tests];
  int        errors    = 0;
  int        cycle_cnt = 0;
  int        seed      = 18914;

  video_top #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back),
    .h_pol    (1'b1),
    .v_pol    (1'b1)
  ) i_video_top (
    .clk      (clk),
    .reset_n  (reset_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .pixel    (pixel)
  );

  // 100 ns clock.
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit.
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: no result after %0d clock cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %0h, actual %0h", test, field, expected, actual);
    end
  endtask

  // ==================================================
  // Wishbone master, driven on the falling edge.
  // ==================================================
  task automatic bus_write(input logic [reg_addr_w-1:0] adr, input logic [31:0] data);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    do begin
      @(negedge clk);
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [reg_addr_w-1:0] adr, output logic [31:0] data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do begin
      @(negedge clk);
    end while (!wb_ack);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Fills one row, expected values from the pattern and sync rules.
  task automatic set_row(input int idx, input string name, input int div,
                         input pattern_e mode, input int h, input int v);
    test_row_t r;
    logic      in_blank;
    logic      square_on;
    r.divider   = div_w'(div);
    r.mode      = mode;
    r.red       = level_w'($random(seed));
    r.green     = level_w'($random(seed));
    r.blue      = level_w'($random(seed));
    r.h         = coord_w'(h);
    r.v         = coord_w'(v);
    in_blank    = (h >= h_active) || (v >= v_active);
    square_on   = (((h >> 3) ^ (v >> 3)) & 1) != 0;
    r.blank_exp = in_blank;
    r.hsync_exp = (h >= hs_start) && (h < hs_start + h_sync);
    r.vsync_exp = (v >= vs_start) && (v < vs_start + v_sync);
    case (mode)
      pat_solid: r.rgb_exp = {r.red, r.green, r.blue};
      pat_hramp: r.rgb_exp = {3{level_w'(h)}};
      pat_vramp: r.rgb_exp = {3{level_w'(v)}};
      default:   r.rgb_exp = square_on ? {r.red, r.green, r.blue} : '0;
    endcase
    // Black in blanking.
    if (in_blank) begin
      r.rgb_exp = '0;
    end
    rows[idx]  = r;
    names[idx] = name;
  endtask

  task automatic build_table();
    set_row(0, "solid_active", 0, pat_solid, 5, 3);
    set_row(1, "solid_hblank", 0, pat_solid, 17, 3);
    set_row(2, "solid_vblank", 1, pat_solid, 6, 10);
    set_row(3, "hramp", 0, pat_hramp, 13, 6);
    set_row(4, "hramp_div2", 2, pat_hramp, 15, 1);
    set_row(5, "vramp", 1, pat_vramp, 4, 7);
    set_row(6, "checker_on", 0, pat_checker, 9, 2);
    set_row(7, "checker_off", 0, pat_checker, 3, 5);
    // Sync edges.
    set_row(8, "hsync_h17", 0, pat_solid, 17, 2);
    set_row(9, "hsync_h18", 0, pat_solid, 18, 2);
    set_row(10, "hsync_h19", 0, pat_solid, 19, 2);
    set_row(11, "hsync_h20", 0, pat_solid, 20, 2);
    set_row(12, "hsync_h21", 0, pat_solid, 21, 2);
    set_row(13, "vsync_v8", 0, pat_solid, 4, 8);
    set_row(14, "vsync_v9", 0, pat_solid, 4, 9);
    set_row(15, "vsync_v10", 0, pat_solid, 4, 10);
    set_row(16, "vsync_v11", 0, pat_solid, 4, 11);
  endtask

  task automatic wait_frame();
    int seen;
    seen = 0;
    while (seen < frame_pixels) begin
      @(negedge clk);
      if (pixel.valid) begin
        seen++;
      end
    end
  endtask

  // Waits for the valid pixel tagged with the row position.
  task automatic find_pixel(input int idx, output logic found);
    int waited;
    found  = 1'b0;
    waited = 0;
    while (!found && waited < 2 * frame_pixels * (max_div + 1)) begin
      @(negedge clk);
      waited++;
      found = pixel.valid && (pixel.hcnt == rows[idx].h) && (pixel.vcnt == rows[idx].v);
    end
    if (!found) begin
      errors++;
      $display("%s: no valid pixel appeared at the target position", names[idx]);
    end
  endtask

  task automatic run_row(input int idx);
    logic found;
    bus_write(reg_red, 32'(rows[idx].red));
    bus_write(reg_green, 32'(rows[idx].green));
    bus_write(reg_blue, 32'(rows[idx].blue));
    bus_write(reg_ctrl, {26'd0, rows[idx].mode, rows[idx].divider, 1'b1});
    // Flush pixels of the previous settings.
    wait_frame();
    find_pixel(idx, found);
    if (found) begin
      check_value(names[idx], "rgb", 32'(rows[idx].rgb_exp), 32'(pixel.rgb));
      check_value(names[idx], "hsync", 32'(rows[idx].hsync_exp), 32'(pixel.hsync));
      check_value(names[idx], "vsync", 32'(rows[idx].vsync_exp), 32'(pixel.vsync));
      check_value(names[idx], "blank", 32'(rows[idx].blank_exp), 32'(pixel.blank));
    end
  endtask

  // ==================================================
  // Register readback, reset values first.
  // ==================================================
  task automatic check_registers();
    logic [31:0] data;
    logic [31:0] written [4];
    for (int a = 0; a < 4; a++) begin
      bus_read(reg_addr_w'(a), data);
      check_value("reset_value", $sformatf("reg%0d", a), 32'd0, data);
    end
    written[0] = 32'hffff_ff3a;
    for (int a = 1; a < 4; a++) begin
      written[a] = $random(seed);
    end
    for (int a = 0; a < 4; a++) begin
      bus_write(reg_addr_w'(a), written[a]);
    end
    // Ctrl keeps bits 5:0, levels keep bits 7:0.
    bus_read(reg_ctrl, data);
    check_value("readback", "reg0", written[0] & 32'h3f, data);
    for (int a = 1; a < 4; a++) begin
      bus_read(reg_addr_w'(a), data);
      check_value("readback", $sformatf("reg%0d", a), written[a] & 32'hff, data);
    end
  endtask

  task automatic check_pixel_rate();
    int gap;
    int seen;
    bus_write(reg_ctrl, {26'd0, pat_solid, 3'd2, 1'b1});
    wait_frame();
    while (!pixel.valid) begin
      @(negedge clk);
    end
    // Divider 2, one pixel every 3 clocks.
    for (int n = 0; n < 8; n++) begin
      gap = 0;
      do begin
        @(negedge clk);
        gap++;
      end while (!pixel.valid);
      check_value("pixel_rate", "gap", 32'd3, 32'(gap));
    end
    bus_write(reg_ctrl, 32'd0);
    // Drain the pipeline.
    repeat (4) @(negedge clk);
    seen = 0;
    repeat (3 * frame_pixels) begin
      @(negedge clk);
      if (pixel.valid) begin
        seen++;
      end
    end
    check_value("enable_off", "valid_count", 32'd0, 32'(seen));
  endtask

  // ==================================================
  // Main sequence.
  // ==================================================
  initial begin
    reset_n  = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    build_table();
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    check_value("reset", "valid", 32'd0, 32'(pixel.valid));
    check_registers();
    for (int i = 0; i < num_tests; i++) begin
      run_row(i);
    end
    check_pixel_rate();
    $display("errors: %0d checks, %0d assertions", errors,
             i_video_top.i_video_props.fail_cnt);
    if (errors == 0 && i_video_top.i_video_props.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: source/channel_pattern.sv
// ==================================================
// One colour channel of the test pattern. Picks the
// component from position, mode and level, and
// registers it one clock behind the timing record.
// ==================================================
`timescale 1ns/1ps

module channel_pattern import video_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  pattern_e           mode,
  input  logic [level_w-1:0] level,
  input  timing_t            timing,
  output logic [level_w-1:0] component
);

  logic [level_w-1:0] pattern_val;
  logic               checker_on;

  // Checker squares of 8 by 8 pixels.
  assign checker_on = timing.hcnt[3] ^ timing.vcnt[3];

  // ==================================================
  // Pattern select.
  // ==================================================
  always_comb begin
    case (mode)
      pat_solid: begin
        pattern_val = level;
      end
      pat_hramp: begin
        // Ramp wraps every 256 pixels.
        pattern_val = timing.hcnt[level_w-1:0];
      end
      pat_vramp: begin
        pattern_val = timing.vcnt[level_w-1:0];
      end
      pat_checker: begin
        pattern_val = checker_on ? level : '0;
      end
      default: begin
        pattern_val = '0;
      end
    endcase
  end

  // Registered every clock, valid or not.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      component <= '0;
    end else begin
      component <= pattern_val;
    end
  end

endmodule

// File: source/pixel_merge.sv
// ==================================================
// Pixel merger. Delays the timing record to line up
// with the channel outputs, gathers rgb, forces black
// in blanking and registers the output pixel.
// ==================================================
`timescale 1ns/1ps

module pixel_merge import video_pkg::*; (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  timing_t                              timing,
  input  logic [num_channels-1:0][level_w-1:0] components,
  output pixel_t                               pixel
);

  timing_t                         timing_q;
  logic [num_channels*level_w-1:0] rgb;

  // Red high, blue low.
  assign rgb = {components[0], components[1], components[2]};

  // ==================================================
  // Stage 1 holds timing, stage 2 is the pixel.
  // ==================================================
  always_ff @(posedge clk) begin
    timing_q    <= timing;
    pixel.hcnt  <= timing_q.hcnt;
    pixel.vcnt  <= timing_q.vcnt;
    pixel.hsync <= timing_q.hsync;
    pixel.vsync <= timing_q.vsync;
    pixel.blank <= timing_q.blank;
    // Black during blanking.
    pixel.rgb   <= timing_q.blank ? '0 : rgb;
    pixel.valid <= timing_q.valid;
    // Only the valid flags are cleared.
    if (!reset_n) begin
      timing_q.valid <= 1'b0;
      pixel.valid    <= 1'b0;
    end
  end

endmodule

// File: source/video_pkg.sv
// ==================================================
// Shared types and constants for the video pattern
// source. Imported by every RTL module.
// ==================================================
package video_pkg;

  // Position counter width, covers 0 to 2047.
  localparam int coord_w = 11;

  // One colour component.
  localparam int level_w = 8;

  // Pixel clock divider field width.
  localparam int div_w = 3;

  // Red, green and blue.
  localparam int num_channels = 3;

  // Wishbone word address width.
  localparam int reg_addr_w = 2;

  // ==================================================
  // Register map, word addresses.
  // ==================================================
  localparam logic [reg_addr_w-1:0] reg_ctrl  = 2'd0;
  localparam logic [reg_addr_w-1:0] reg_red   = 2'd1;
  localparam logic [reg_addr_w-1:0] reg_green = 2'd2;
  localparam logic [reg_addr_w-1:0] reg_blue  = 2'd3;

  // Pattern selection.
  typedef enum logic [1:0] {
    pat_solid   = 2'd0,
    pat_hramp   = 2'd1,
    pat_vramp   = 2'd2,
    pat_checker = 2'd3
  } pattern_e;

  // One timing event from the generator.
  typedef struct packed {
    logic               valid;
    logic [coord_w-1:0] hcnt;
    logic [coord_w-1:0] vcnt;
    logic               hsync;
    logic               vsync;
    logic               blank;
  } timing_t;

  // Control fields held by the register slave.
  typedef struct packed {
    logic             enable;
    logic [div_w-1:0] divider;
    pattern_e         mode;
  } ctrl_t;

  // Output pixel record, red in the high byte.
  typedef struct packed {
    logic                            valid;
    logic [coord_w-1:0]              hcnt;
    logic [coord_w-1:0]              vcnt;
    logic                            hsync;
    logic                            vsync;
    logic                            blank;
    logic [num_channels*level_w-1:0] rgb;
  } pixel_t;

endpackage

// File: source/video_timing.sv
// ==================================================
// Video timing generator. Produces a pixel enable from
// clk, counts h and v positions and decodes sync and
// blank into a registered timing record.
// ==================================================
`timescale 1ns/1ps

module video_timing import video_pkg::*; #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33,
  parameter bit h_pol    = 1'b0,
  parameter bit v_pol    = 1'b0
) (
  input  logic    clk,
  input  logic    reset_n,
  input  ctrl_t   ctrl,
  output timing_t timing
);

  // ==================================================
  // Frame geometry.
  // ==================================================
  localparam int h_total = h_active + h_front + h_sync + h_back;
  localparam int v_total = v_active + v_front + v_sync + v_back;

  localparam logic [coord_w-1:0] h_last       = coord_w'(h_total - 1);
  localparam logic [coord_w-1:0] v_last       = coord_w'(v_total - 1);
  localparam logic [coord_w-1:0] h_sync_start = coord_w'(h_active + h_front);
  localparam logic [coord_w-1:0] h_sync_end   = coord_w'(h_active + h_front + h_sync);
  localparam logic [coord_w-1:0] v_sync_start = coord_w'(v_active + v_front);
  localparam logic [coord_w-1:0] v_sync_end   = coord_w'(v_active + v_front + v_sync);
  localparam logic [coord_w-1:0] h_vis        = coord_w'(h_active);
  localparam logic [coord_w-1:0] v_vis        = coord_w'(v_active);

  logic [div_w-1:0]   div_cnt;
  logic               pix_en;
  logic [coord_w-1:0] h_cnt;
  logic [coord_w-1:0] v_cnt;
  logic               h_in_sync;
  logic               v_in_sync;
  logic               in_blank;

  // One enable every divider+1 clocks.
  assign pix_en = ctrl.enable && (div_cnt == '0);

  // Divider counter, parked at zero while disabled.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      div_cnt <= '0;
    end else if (!ctrl.enable) begin
      div_cnt <= '0;
    end else if (div_cnt >= ctrl.divider) begin
      // Also catches a divider lowered mid-count.
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // ==================================================
  // Position counters.
  // ==================================================
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!ctrl.enable) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (pix_en) begin
      if (h_cnt == h_last) begin
        h_cnt <= '0;
        // Line done, step the frame.
        v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Sync windows and blanking from the current counts.
  assign h_in_sync = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
  assign v_in_sync = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);
  assign in_blank  = (h_cnt >= h_vis) || (v_cnt >= v_vis);

  // Registered record, tagged with the counts it decodes.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      timing.valid <= 1'b0;
      timing.hcnt  <= '0;
      timing.vcnt  <= '0;
      timing.hsync <= ~h_pol;
      timing.vsync <= ~v_pol;
      timing.blank <= 1'b1;
    end else begin
      timing.valid <= pix_en;
      timing.hcnt  <= h_cnt;
      timing.vcnt  <= v_cnt;
      // Polarity applied here.
      timing.hsync <= h_in_sync ~^ h_pol;
      timing.vsync <= v_in_sync ~^ v_pol;
      timing.blank <= in_blank;
    end
  end

endmodule

// File: source/video_top.sv
// ==================================================
// Video test pattern source top level. Wishbone
// registers, timing generator, three colour channels
// and the pixel merger. Geometry is set here.
// ==================================================
`timescale 1ns/1ps

module video_top import video_pkg::*; #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33,
  parameter bit h_pol    = 1'b0,
  parameter bit v_pol    = 1'b0
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [reg_addr_w-1:0] wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  output pixel_t                pixel
);

  ctrl_t                                ctrl;
  logic [num_channels-1:0][level_w-1:0] levels;
  logic [num_channels-1:0][level_w-1:0] components;
  timing_t                              timing;

  // Control registers.
  wb_video_regs i_wb_video_regs (
    .clk      (clk),
    .reset_n  (reset_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .ctrl     (ctrl),
    .levels   (levels)
  );

  // Timing generator.
  video_timing #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back),
    .h_pol    (h_pol),
    .v_pol    (v_pol)
  ) i_video_timing (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl),
    .timing  (timing)
  );

  // ==================================================
  // Colour channels, 0 red, 1 green, 2 blue.
  // ==================================================
  for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
    channel_pattern i_channel_pattern (
      .clk       (clk),
      .reset_n   (reset_n),
      .mode      (ctrl.mode),
      .level     (levels[ch]),
      .timing    (timing),
      .component (components[ch])
    );
  end

  // Output stage.
  pixel_merge i_pixel_merge (
    .clk        (clk),
    .reset_n    (reset_n),
    .timing     (timing),
    .components (components),
    .pixel      (pixel)
  );

endmodule

// File: source/wb_video_regs.sv
// ==================================================
// Wishbone classic slave with the video control
// register and the three channel level registers.
// Single-cycle ack, no bursts.
// ==================================================
`timescale 1ns/1ps

module wb_video_regs import video_pkg::*; (
  input  logic                                   clk,
  input  logic                                   reset_n,
  input  logic                                   wb_cyc,
  input  logic                                   wb_stb,
  input  logic                                   wb_we,
  input  logic [reg_addr_w-1:0]                  wb_adr,
  input  logic [31:0]                            wb_dat_w,
  output logic [31:0]                            wb_dat_r,
  output logic                                   wb_ack,
  output ctrl_t                                  ctrl,
  output logic [num_channels-1:0][level_w-1:0]   levels
);

  logic bus_req;
  logic wr_en;

  // New request only while no ack is out.
  assign bus_req = wb_cyc && wb_stb && !wb_ack;
  assign wr_en   = bus_req && wb_we;

  // ==================================================
  // Handshake.
  // ==================================================
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wb_ack <= 1'b0;
    end else begin
      // Ack for exactly one cycle.
      wb_ack <= bus_req;
    end
  end

  // ==================================================
  // Register writes, same edge as the ack.
  // ==================================================
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ctrl   <= '0;
      levels <= '0;
    end else if (wr_en) begin
      case (wb_adr)
        reg_ctrl: begin
          ctrl.enable  <= wb_dat_w[0];
          ctrl.divider <= wb_dat_w[3:1];
          ctrl.mode    <= pattern_e'(wb_dat_w[5:4]);
        end
        reg_red:   levels[0] <= wb_dat_w[level_w-1:0];
        reg_green: levels[1] <= wb_dat_w[level_w-1:0];
        reg_blue:  levels[2] <= wb_dat_w[level_w-1:0];
        default: begin
        end
      endcase
    end
  end

  // Read mux, zero extended.
  always_comb begin
    wb_dat_r = '0;
    case (wb_adr)
      reg_ctrl: begin
        wb_dat_r[0]   = ctrl.enable;
        wb_dat_r[3:1] = ctrl.divider;
        wb_dat_r[5:4] = ctrl.mode;
      end
      reg_red:   wb_dat_r[level_w-1:0] = levels[0];
      reg_green: wb_dat_r[level_w-1:0] = levels[1];
      reg_blue:  wb_dat_r[level_w-1:0] = levels[2];
      default:   wb_dat_r = '0;
    endcase
  end

endmodule
